// ==== design/dispatch_consts.svh ====
`ifndef DispatchConstsSvh
`define DispatchConstsSvh

// architectural registers, x0 included
`define RegCount 32

// register value and immediate width
`define DataWidth 32

// instruction address width
`define AddrWidth 32

// op code handed through to the execution units
`define OpWidth 6

// entries in each tag pool
`define TagPoolDepth 8

// upper tag bits pick the pool
`define AluTagPrefix 2'b01
`define LsTagPrefix 2'b10

// tag zero means the value is present, no producer pending
`define TagFree 5'b00000

`endif

// ==== design/renamePkg.sv ====
`include "dispatch_consts.svh"

package renamePkg;

    typedef logic [$clog2(`RegCount)-1:0] regName_t;

    typedef logic [`DataWidth-1:0] data_t;

    typedef logic [1:0] tagPrefix_t;

    typedef logic [$clog2(`TagPoolDepth)-1:0] tagIndex_t;

    // prefix selects the pool, index the slot in it
    typedef struct packed {
        tagPrefix_t prefix;
        tagIndex_t  index;
    } tag_t;

    // result broadcast from an execution unit
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cdb_t;

    // tag handed back at commit
    typedef struct packed {
        logic valid;
        tag_t tag;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        logic [`OpWidth-1:0]   op;
        data_t                 operandO;
        data_t                 operandT;
        tag_t                  tagO;
        tag_t                  tagT;
        tag_t                  tagW;
        regName_t              nameW;
        logic [`AddrWidth-1:0] addr;
    } aluEntry_t;

    typedef struct packed {
        logic                  valid;
        logic [`OpWidth-1:0]   op;
        data_t                 operandO;
        data_t                 operandT;
        tag_t                  tagO;
        tag_t                  tagT;
        data_t                 imm;
        logic [`AddrWidth-1:0] addr;
    } branchEntry_t;

    typedef struct packed {
        logic                valid;
        logic [`OpWidth-1:0] op;
        data_t               operandO;
        data_t               operandT;
        tag_t                tagO;
        tag_t                tagT;
        tag_t                tagW;
        regName_t            nameW;
        data_t               imm;
    } lsEntry_t;

endpackage

// ==== design/isaPkg.sv ====
`include "dispatch_consts.svh"

package isaPkg;

    // instruction class as the decoder reports it
    typedef enum logic [3:0] {
        ClassLui   = 4'd0,
        ClassAuipc = 4'd1,
        ClassJal   = 4'd2,
        ClassJalr  = 4'd3,
        ClassB     = 4'd4,
        ClassLd    = 4'd5,
        ClassSt    = 4'd6,
        ClassRi    = 4'd7,
        ClassRr    = 4'd8
    } opClass_t;

    typedef logic [`OpWidth-1:0] opCode_t;

    typedef logic [`AddrWidth-1:0] instAddr_t;

    // one decoded instruction
    // imm is already the right form for the class (I, S, B, U or J)
    typedef struct packed {
        opClass_t            opClass;
        opCode_t             opCode;
        instAddr_t           instAddr;
        renamePkg::regName_t rsO;
        renamePkg::regName_t rsT;
        renamePkg::regName_t rd;
        renamePkg::data_t    imm;
    } decodedInst_t;

endpackage

// ==== design/renameTable.sv ====
`timescale 1ns/100ps
`include "dispatch_consts.svh"

module renameTable (
    input  logic                clk,
    input  logic                reset,
    input  renamePkg::regName_t readNameO,
    input  renamePkg::regName_t readNameT,
    output renamePkg::tag_t     readTagO,
    output renamePkg::tag_t     readTagT,
    output renamePkg::data_t    readDataO,
    output renamePkg::data_t    readDataT,
    input  logic                renameEn,
    input  renamePkg::regName_t renameName,
    input  renamePkg::tag_t     renameTag,
    input  renamePkg::cdb_t     cdb
);

    renamePkg::tag_t  tagTable [`RegCount];
    renamePkg::data_t dataTable [`RegCount];

    logic cdbLive;
    logic renameLive;

    // a free tag on the bus would match every ready entry
    assign cdbLive = cdb.valid && (cdb.tag != `TagFree);

    // x0 is never renamed
    assign renameLive = renameEn && (renameName != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RegCount; i++) begin
                tagTable[i] <= `TagFree;
                dataTable[i] <= '0;
            end
        end else begin
            // capture the broadcast in every waiting entry
            for (int i = 1; i < `RegCount; i++) begin
                if (cdbLive && (tagTable[i] == cdb.tag)) begin
                    tagTable[i] <= `TagFree;
                    dataTable[i] <= cdb.data;
                end
            end
            // later assignment, so a rename on the same edge wins
            if (renameLive) begin
                tagTable[renameName] <= renameTag;
            end
        end
    end

    // entry 0 keeps its reset contents, tag free and value zero
    assign readTagO = tagTable[readNameO];
    assign readTagT = tagTable[readNameT];
    assign readDataO = dataTable[readNameO];
    assign readDataT = dataTable[readNameT];

endmodule

// ==== design/tagFreeList.sv ====
`timescale 1ns/100ps
`include "dispatch_consts.svh"

module tagFreeList #(
    parameter renamePkg::tagPrefix_t PoolPrefix = `AluTagPrefix
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 allocEn,
    output renamePkg::tagIndex_t freeIndex,
    output logic                 anyFree,
    input  renamePkg::retire_t   retire
);

    // one bit per slot, set while the slot is free
    logic [`TagPoolDepth-1:0] freeMap;

    logic releaseHit;

    // only retires from this pool touch the map
    assign releaseHit = retire.valid && (retire.tag.prefix == PoolPrefix);

    assign anyFree = |freeMap;

    // lowest free slot, scanned from the top down
    always_comb begin
        freeIndex = '0;
        for (int i = `TagPoolDepth - 1; i >= 0; i--) begin
            if (freeMap[i]) begin
                freeIndex = renamePkg::tagIndex_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            freeMap <= '1;
        end else begin
            if (allocEn) begin
                freeMap[freeIndex] <= 1'b0;
            end
            // a retired slot is never the one being allocated
            if (releaseHit) begin
                freeMap[retire.tag.index] <= 1'b1;
            end
        end
    end

endmodule

// ==== design/dispatcher.sv ====
`timescale 1ns/100ps
`include "dispatch_consts.svh"

module dispatcher (
    input  logic                   clk,
    input  logic                   reset,
    input  isaPkg::decodedInst_t   inst,
    input  logic                   instValid,
    output logic                   accept,
    output renamePkg::regName_t    readNameO,
    output renamePkg::regName_t    readNameT,
    input  renamePkg::tag_t        readTagO,
    input  renamePkg::tag_t        readTagT,
    input  renamePkg::data_t       readDataO,
    input  renamePkg::data_t       readDataT,
    output logic                   renameEn,
    output renamePkg::regName_t    renameName,
    output renamePkg::tag_t        renameTag,
    input  renamePkg::tagIndex_t   aluFreeIndex,
    input  renamePkg::tagIndex_t   lsFreeIndex,
    input  logic                   aluAnyFree,
    input  logic                   lsAnyFree,
    output logic                   aluAllocEn,
    output logic                   lsAllocEn,
    input  renamePkg::cdb_t        cdb,
    input  logic                   aluReady,
    input  logic                   branchReady,
    input  logic                   lsReady,
    input  logic                   misTaken,
    output renamePkg::aluEntry_t   aluIssue,
    output renamePkg::branchEntry_t branchIssue,
    output renamePkg::lsEntry_t    lsIssue
);

    logic isLs;
    logic isBranch;
    logic portReady;
    logic tagReady;
    renamePkg::tag_t newTag;
    renamePkg::tag_t srcTagO;
    renamePkg::tag_t srcTagT;
    renamePkg::data_t srcDataO;
    renamePkg::data_t srcDataT;
    renamePkg::aluEntry_t aluNext;
    renamePkg::branchEntry_t branchNext;
    renamePkg::lsEntry_t lsNext;

    assign isLs = (inst.opClass == isaPkg::ClassLd) || (inst.opClass == isaPkg::ClassSt);
    assign isBranch = (inst.opClass == isaPkg::ClassB);

    assign portReady = isLs ? lsReady : (isBranch ? branchReady : aluReady);

    // branches need no tag
    assign tagReady = isBranch || (isLs ? lsAnyFree : aluAnyFree);

    assign accept = instValid && !misTaken && portReady && tagReady;

    assign newTag.prefix = isLs ? `LsTagPrefix : `AluTagPrefix;
    assign newTag.index = isLs ? lsFreeIndex : aluFreeIndex;

    assign aluAllocEn = accept && !isLs && !isBranch;
    assign lsAllocEn = accept && isLs;

    // stores and branches write no register
    assign renameEn = accept && !isBranch && (inst.opClass != isaPkg::ClassSt) && (inst.rd != '0);
    assign renameName = inst.rd;
    assign renameTag = newTag;

    assign readNameO = inst.rsO;
    assign readNameT = inst.rsT;

    // bypass a result broadcast on this very cycle
    always_comb begin
        srcTagO = readTagO;
        srcDataO = readDataO;
        if (cdb.valid && (readTagO != `TagFree) && (cdb.tag == readTagO)) begin
            srcTagO = `TagFree;
            srcDataO = cdb.data;
        end
        srcTagT = readTagT;
        srcDataT = readDataT;
        if (cdb.valid && (readTagT != `TagFree) && (cdb.tag == readTagT)) begin
            srcTagT = `TagFree;
            srcDataT = cdb.data;
        end
    end

    always_comb begin
        aluNext = '0;
        branchNext = '0;
        lsNext = '0;
        case (inst.opClass)
            isaPkg::ClassLui, isaPkg::ClassAuipc, isaPkg::ClassJalr, isaPkg::ClassRi: begin
                aluNext.operandO = srcDataO;
                aluNext.tagO = srcTagO;
                aluNext.operandT = inst.imm;
            end
            isaPkg::ClassJal: begin
                // link address computed from the pc
                aluNext.operandO = inst.instAddr;
                aluNext.operandT = inst.imm;
            end
            isaPkg::ClassB: begin
                branchNext.operandO = srcDataO;
                branchNext.tagO = srcTagO;
                branchNext.operandT = srcDataT;
                branchNext.tagT = srcTagT;
                branchNext.imm = inst.imm;
            end
            isaPkg::ClassLd: begin
                lsNext.operandO = srcDataO;
                lsNext.tagO = srcTagO;
                lsNext.nameW = inst.rd;
            end
            isaPkg::ClassSt: begin
                lsNext.operandO = srcDataO;
                lsNext.tagO = srcTagO;
                lsNext.operandT = srcDataT;
                lsNext.tagT = srcTagT;
            end
            default: begin
                // RR reads two register sources
                aluNext.operandO = srcDataO;
                aluNext.tagO = srcTagO;
                aluNext.operandT = srcDataT;
                aluNext.tagT = srcTagT;
            end
        endcase
        aluNext.valid = accept && !isLs && !isBranch;
        aluNext.op = inst.opCode;
        aluNext.tagW = newTag;
        aluNext.nameW = inst.rd;
        aluNext.addr = inst.instAddr;
        branchNext.valid = accept && isBranch;
        branchNext.op = inst.opCode;
        branchNext.addr = inst.instAddr;
        lsNext.valid = accept && isLs;
        lsNext.op = inst.opCode;
        lsNext.tagW = newTag;
        lsNext.imm = inst.imm;
    end

    // the issue valid lasts one cycle per accepted instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            aluIssue.valid <= 1'b0;
            branchIssue.valid <= 1'b0;
            lsIssue.valid <= 1'b0;
        end else begin
            aluIssue <= aluNext;
            branchIssue <= branchNext;
            lsIssue <= lsNext;
        end
    end

endmodule

// ==== design/dispatchTop.sv ====
`timescale 1ns/100ps
`include "dispatch_consts.svh"

module dispatchTop (
    input  logic                    clk,
    input  logic                    reset,
    input  isaPkg::decodedInst_t    inst,
    input  logic                    instValid,
    output logic                    accept,
    input  renamePkg::cdb_t         cdb,
    input  renamePkg::retire_t      retire,
    input  logic                    aluReady,
    input  logic                    branchReady,
    input  logic                    lsReady,
    input  logic                    misTaken,
    output renamePkg::aluEntry_t    aluIssue,
    output renamePkg::branchEntry_t branchIssue,
    output renamePkg::lsEntry_t     lsIssue
);

    renamePkg::regName_t readNameO;
    renamePkg::regName_t readNameT;
    renamePkg::tag_t readTagO;
    renamePkg::tag_t readTagT;
    renamePkg::data_t readDataO;
    renamePkg::data_t readDataT;
    logic renameEn;
    renamePkg::regName_t renameName;
    renamePkg::tag_t renameTag;
    renamePkg::tagIndex_t aluFreeIndex;
    renamePkg::tagIndex_t lsFreeIndex;
    logic aluAnyFree;
    logic lsAnyFree;
    logic aluAllocEn;
    logic lsAllocEn;

    renameTable regTable (
        .clk        (clk),
        .reset      (reset),
        .readNameO  (readNameO),
        .readNameT  (readNameT),
        .readTagO   (readTagO),
        .readTagT   (readTagT),
        .readDataO  (readDataO),
        .readDataT  (readDataT),
        .renameEn   (renameEn),
        .renameName (renameName),
        .renameTag  (renameTag),
        .cdb        (cdb)
    );

    tagFreeList #(.PoolPrefix(`AluTagPrefix)) aluTags (
        .clk       (clk),
        .reset     (reset),
        .allocEn   (aluAllocEn),
        .freeIndex (aluFreeIndex),
        .anyFree   (aluAnyFree),
        .retire    (retire)
    );

    tagFreeList #(.PoolPrefix(`LsTagPrefix)) lsTags (
        .clk       (clk),
        .reset     (reset),
        .allocEn   (lsAllocEn),
        .freeIndex (lsFreeIndex),
        .anyFree   (lsAnyFree),
        .retire    (retire)
    );

    dispatcher control (
        .clk          (clk),
        .reset        (reset),
        .inst         (inst),
        .instValid    (instValid),
        .accept       (accept),
        .readNameO    (readNameO),
        .readNameT    (readNameT),
        .readTagO     (readTagO),
        .readTagT     (readTagT),
        .readDataO    (readDataO),
        .readDataT    (readDataT),
        .renameEn     (renameEn),
        .renameName   (renameName),
        .renameTag    (renameTag),
        .aluFreeIndex (aluFreeIndex),
        .lsFreeIndex  (lsFreeIndex),
        .aluAnyFree   (aluAnyFree),
        .lsAnyFree    (lsAnyFree),
        .aluAllocEn   (aluAllocEn),
        .lsAllocEn    (lsAllocEn),
        .cdb          (cdb),
        .aluReady     (aluReady),
        .branchReady  (branchReady),
        .lsReady      (lsReady),
        .misTaken     (misTaken),
        .aluIssue     (aluIssue),
        .branchIssue  (branchIssue),
        .lsIssue      (lsIssue)
    );

endmodule

// ==== tb/dispatchTb.sv ====
`timescale 1ns/100ps

module dispatchTb;

    localparam int ClockPeriod = 20;
    localparam int MaxVectors = 64;
    localparam int ColCount = 25;
    localparam int WatchMargin = 400;

    logic clk;
    logic reset;
    isaPkg::decodedInst_t inst;
    logic instValid;
    logic accept;
    renamePkg::cdb_t cdb;
    renamePkg::retire_t retire;
    logic aluReady;
    logic branchReady;
    logic lsReady;
    logic misTaken;
    renamePkg::aluEntry_t aluIssue;
    renamePkg::branchEntry_t branchIssue;
    renamePkg::lsEntry_t lsIssue;

    // one row per vector line with the columns of the file header
    logic [31:0] vec [MaxVectors][ColCount];
    int vectorCount;
    int errorCount;
    logic loaded;

    dispatchTop UUT (
        .clk         (clk),
        .reset       (reset),
        .inst        (inst),
        .instValid   (instValid),
        .accept      (accept),
        .cdb         (cdb),
        .retire      (retire),
        .aluReady    (aluReady),
        .branchReady (branchReady),
        .lsReady     (lsReady),
        .misTaken    (misTaken),
        .aluIssue    (aluIssue),
        .branchIssue (branchIssue),
        .lsIssue     (lsIssue)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #(ClockPeriod / 2) clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic readVectors();
        int fd;
        int got;
        int n;
        string line;
        n = 0;
        fd = $fopen("tb/dispatch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file tb/dispatch_vectors.txt");
            errorCount++;
        end else begin
            while (!$feof(fd) && n < MaxVectors) begin
                line = "";
                got = $fgets(line, fd);
                // comment and blank lines carry no vector
                if (got > 1 && line.getc(0) != "/") begin
                    got = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vec[n][0], vec[n][1], vec[n][2], vec[n][3], vec[n][4],
                        vec[n][5], vec[n][6], vec[n][7], vec[n][8], vec[n][9],
                        vec[n][10], vec[n][11], vec[n][12], vec[n][13], vec[n][14],
                        vec[n][15], vec[n][16], vec[n][17], vec[n][18], vec[n][19],
                        vec[n][20], vec[n][21], vec[n][22], vec[n][23], vec[n][24]);
                    if (got == ColCount) begin
                        n++;
                    end else begin
                        $display("vector line %0d has only %0d readable columns", n, got);
                        errorCount++;
                    end
                end
            end
            $fclose(fd);
        end
        vectorCount = n;
    endtask

    task automatic driveRow(input int r);
        inst.opClass = isaPkg::opClass_t'(vec[r][0][3:0]);
        inst.opCode = vec[r][1][5:0];
        inst.instAddr = vec[r][2];
        inst.rsO = vec[r][3][4:0];
        inst.rsT = vec[r][4][4:0];
        inst.rd = vec[r][5][4:0];
        inst.imm = vec[r][6];
        instValid = vec[r][7][0];
        cdb.valid = vec[r][8][0];
        cdb.tag = vec[r][9][4:0];
        cdb.data = vec[r][10];
        retire.valid = vec[r][11][0];
        retire.tag = vec[r][12][4:0];
        aluReady = vec[r][13][0];
        branchReady = vec[r][14][0];
        lsReady = vec[r][15][0];
        misTaken = vec[r][16][0];
    endtask

    task automatic driveIdle();
        instValid = 1'b0;
        cdb.valid = 1'b0;
        retire.valid = 1'b0;
        aluReady = 1'b1;
        branchReady = 1'b1;
        lsReady = 1'b1;
        misTaken = 1'b0;
    endtask

    // issue register holds the packet of row r, or nothing when r is negative
    task automatic checkIssue(input int r);
        logic [31:0] port;
        port = (r < 0) ? 32'd0 : vec[r][18];
        checkValue("aluIssue.valid", 32'(port == 1), 32'(aluIssue.valid));
        checkValue("branchIssue.valid", 32'(port == 2), 32'(branchIssue.valid));
        checkValue("lsIssue.valid", 32'(port == 3), 32'(lsIssue.valid));
        if (port == 1) begin
            checkValue("aluIssue.op", vec[r][1], 32'(aluIssue.op));
            checkValue("aluIssue.addr", vec[r][2], aluIssue.addr);
            checkValue("aluIssue.tagO", vec[r][21], 32'(aluIssue.tagO));
            checkValue("aluIssue.tagT", vec[r][22], 32'(aluIssue.tagT));
            checkValue("aluIssue.tagW", vec[r][23], 32'(aluIssue.tagW));
            checkValue("aluIssue.nameW", vec[r][24], 32'(aluIssue.nameW));
            // a pending operand has no meaningful value yet
            if (vec[r][21] == 0) begin
                checkValue("aluIssue.operandO", vec[r][19], aluIssue.operandO);
            end
            if (vec[r][22] == 0) begin
                checkValue("aluIssue.operandT", vec[r][20], aluIssue.operandT);
            end
        end
        if (port == 2) begin
            checkValue("branchIssue.op", vec[r][1], 32'(branchIssue.op));
            checkValue("branchIssue.addr", vec[r][2], branchIssue.addr);
            checkValue("branchIssue.imm", vec[r][6], branchIssue.imm);
            checkValue("branchIssue.tagO", vec[r][21], 32'(branchIssue.tagO));
            checkValue("branchIssue.tagT", vec[r][22], 32'(branchIssue.tagT));
            if (vec[r][21] == 0) begin
                checkValue("branchIssue.operandO", vec[r][19], branchIssue.operandO);
            end
            if (vec[r][22] == 0) begin
                checkValue("branchIssue.operandT", vec[r][20], branchIssue.operandT);
            end
        end
        if (port == 3) begin
            checkValue("lsIssue.op", vec[r][1], 32'(lsIssue.op));
            checkValue("lsIssue.imm", vec[r][6], lsIssue.imm);
            checkValue("lsIssue.tagO", vec[r][21], 32'(lsIssue.tagO));
            checkValue("lsIssue.tagT", vec[r][22], 32'(lsIssue.tagT));
            checkValue("lsIssue.tagW", vec[r][23], 32'(lsIssue.tagW));
            checkValue("lsIssue.nameW", vec[r][24], 32'(lsIssue.nameW));
            if (vec[r][21] == 0) begin
                checkValue("lsIssue.operandO", vec[r][19], lsIssue.operandO);
            end
            if (vec[r][22] == 0) begin
                checkValue("lsIssue.operandT", vec[r][20], lsIssue.operandT);
            end
        end
    endtask

    // a flush holds back a load whose port and tag pool are both ready
    task automatic checkFlushHold();
        inst = '0;
        inst.opClass = isaPkg::ClassLd;
        inst.opCode = 6'h0a;
        instValid = 1'b1;
        misTaken = 1'b1;
        #(ClockPeriod / 4);
        checkValue("accept", 32'd0, 32'(accept));
        @(negedge clk);
        checkIssue(-1);
        misTaken = 1'b0;
        #(ClockPeriod / 4);
        checkValue("accept", 32'd1, 32'(accept));
        @(negedge clk);
        checkValue("lsIssue.valid", 32'd1, 32'(lsIssue.valid));
        // the vectors take three load/store tags, so the fourth comes next
        checkValue("lsIssue.tagW", 32'h13, 32'(lsIssue.tagW));
        driveIdle();
    endtask

    initial begin
        int lastRow;
        int gap;
        void'($urandom(59330));
        errorCount = 0;
        vectorCount = 0;
        loaded = 1'b0;
        reset = 1'b1;
        inst = '0;
        cdb = '0;
        retire = '0;
        driveIdle();
        // an instruction offered during reset must not reach the issue register
        instValid = 1'b1;
        readVectors();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkIssue(-1);
        driveIdle();
        reset = 1'b0;
        lastRow = -1;
        for (int i = 0; i < vectorCount; i++) begin
            @(negedge clk);
            checkIssue(lastRow);
            driveRow(i);
            #(ClockPeriod / 4);
            checkValue("accept", vec[i][17], 32'(accept));
            lastRow = i;
            // idle gaps only where no stalled instruction is being held
            if (vec[i][7] == 0 || vec[i][17] == 1) begin
                gap = $urandom % 2;
                repeat (gap) begin
                    @(negedge clk);
                    checkIssue(lastRow);
                    driveIdle();
                    lastRow = -1;
                end
            end
        end
        @(negedge clk);
        checkIssue(lastRow);
        driveIdle();
        checkFlushHold();
        $display("errors: %0d over %0d vectors", errorCount, vectorCount);
        if (errorCount == 0 && vectorCount > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // a vector takes two cycles at most
    initial begin
        wait (loaded);
        #(vectorCount * 40 + WatchMargin);
        $display("timeout: the vector run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== tb/dispatch_vectors.txt ====
// cls op addr rsO rsT rd imm iv cv ctag cdata rv rtag aR bR lR mis, then expected:
// acc port(0 none 1 alu 2 branch 3 ls) opO opT tagO tagT tagW nameW, all hex
7 01 100 00 00 01 5 1 0 00 0 0 00 1 1 1 0 1 1 0 5 00 00 08 01
8 02 104 00 00 02 0 1 0 00 0 0 00 1 1 1 0 1 1 0 0 00 00 09 02
8 02 108 00 00 00 0 1 0 00 0 0 00 1 1 1 0 1 1 0 0 00 00 0a 00
0 00 000 00 00 00 0 0 1 08 11 0 00 1 1 1 0 0 0 0 0 00 00 00 00
8 02 10c 01 02 03 0 1 0 00 0 0 00 1 1 1 0 1 1 11 0 00 09 0b 03
0 00 000 00 00 00 0 0 1 09 22 0 00 1 1 1 0 0 0 0 0 00 00 00 00
8 02 110 02 03 04 0 1 1 0b 33 0 00 1 1 1 0 1 1 22 33 00 00 0c 04
5 03 114 03 00 05 8 1 0 00 0 0 00 1 1 1 0 1 3 33 0 00 00 10 05
6 04 118 01 05 07 4 1 0 00 0 0 00 1 1 1 0 1 3 11 0 00 10 11 00
2 05 200 00 00 01 40 1 0 00 0 0 00 1 1 1 0 1 1 200 40 00 00 0d 01
8 02 11c 07 01 06 0 1 0 00 0 0 00 1 1 1 0 1 1 0 11 00 0d 0e 06
4 06 120 03 02 00 10 1 0 00 0 0 00 1 1 1 0 1 2 33 22 00 00 00 00
7 01 124 03 00 08 7 1 0 00 0 0 00 1 1 1 0 1 1 33 7 00 00 0f 08
8 02 128 00 00 09 0 1 0 00 0 0 00 1 1 1 0 0 0 0 0 00 00 00 00
8 02 128 00 00 09 0 1 0 00 0 1 0c 1 1 1 0 0 0 0 0 00 00 00 00
8 02 128 00 00 09 0 1 0 00 0 0 00 1 1 1 0 1 1 0 0 00 00 0c 09
5 03 12c 00 00 0a 0 1 0 00 0 0 00 1 1 0 0 0 0 0 0 00 00 00 00
5 03 12c 00 00 0a 0 1 0 00 0 0 00 1 1 1 0 1 3 0 0 00 00 12 0a
7 01 130 00 00 03 1 1 0 00 0 1 08 1 1 1 1 0 0 0 0 00 00 00 00
8 02 134 03 09 0b 0 1 0 00 0 0 00 1 1 1 0 1 1 33 0 00 0c 08 0b
0 00 000 00 00 00 0 0 1 0c 44 1 09 1 1 1 0 0 0 0 0 00 00 00 00
8 02 138 04 09 00 0 1 0 00 0 1 0a 1 1 1 0 1 1 44 44 00 00 09 00
3 07 13c 01 00 0c c 1 0 00 0 1 0b 1 1 1 0 1 1 11 c 0d 00 0a 0c
1 08 140 01 00 0d 1000 1 1 0d 55 1 0e 1 1 1 0 1 1 55 1000 00 00 0b 0d
0 09 144 00 00 0e 2000 1 0 00 0 0 00 1 1 1 0 1 1 0 2000 00 00 0e 0e
0 00 000 00 00 00 0 0 0 00 0 0 00 1 1 1 0 0 0 0 0 00 00 00 00

// ==== verilog.f ====
+incdir+design
design/renamePkg.sv
design/isaPkg.sv
design/renameTable.sv
design/tagFreeList.sv
design/dispatcher.sv
design/dispatchTop.sv
tb/dispatchTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST ?= verilog.f
TOP ?= dispatchTb
RTL_TOP ?= dispatchTop
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
